// File: compile.f
design/qnet_pkg.sv
design/qnet_cmd_intake.sv
design/qnet_cmd_exec.sv
design/qnet_node_regs.sv
design/qnet_tx_stage.sv
design/qnet_cmd_top.sv
dv/qnet_tb_checker.sv
dv/qnet_tb_top.sv

// File: design/qnet_cmd_exec.sv
`timescale 1ns/1ps

module qnet_cmd_exec import qnet_pkg::*; #(
   parameter logic [31:0] T_LINK = 32'd20
) (
   // Command from intake
   input  logic        cmd_valid_i,
   input  qnet_cmd_t   cmd_i,
   output logic        cmd_ready_o,
   // Node parameters
   input  qnet_param_t param_i,
   output qnet_pwr_t   pwr_o,
   // Message towards transmit
   output logic        msg_valid_o,
   output qnet_msg_t   msg_o,
   input  logic        msg_ready_i,
   // Time control and status
   output logic        time_reset_o,
   output logic        time_init_o,
   output logic        time_updt_o,
   output logic        cmd_err_o
);

   qnet_hdr_t hdr;
   logic      known;
   logic      accept;
   qnet_pwr_t pwr;
   logic      t_reset;
   logic      t_init;
   logic      t_updt;

   assign hdr   = cmd_i.msg.hdr;
   assign known = hdr.id inside {GET_NET, SET_NET, SYNC1, UPDT_OFF, SET_DT, GET_DT};

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////

   // Every known ID sends a message, so it waits for a free tx slot
   assign cmd_ready_o = !known || msg_ready_i;
   assign accept      = cmd_valid_i && cmd_ready_o;
   assign msg_valid_o = cmd_valid_i && known;
   assign cmd_err_o   = cmd_valid_i && !known;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      pwr       = '0;
      t_reset   = 1'b0;
      t_init    = 1'b0;
      t_updt    = 1'b0;
      msg_o     = '0;
      msg_o.hdr = hdr;
      case (hdr.id)
         GET_NET: begin
            pwr.we_id = 1'b1;
            if (cmd_i.net) begin
               pwr.val10 = hdr.hdt[QNET_ADDR_W-1:0];
               msg_o.hdr = qnet_hdr_t'(64'(hdr) + 64'd1);
               t_reset   = 1'b1;
            end else begin
               // Origin of the ring
               pwr.val10 = QNET_ADDR_W'(1);
            end
         end
         SET_NET: begin
            if (cmd_i.net) begin
               pwr.we_rtd = 1'b1;
               pwr.we_nn  = 1'b1;
               pwr.val32  = cmd_i.msg.dt1;
               pwr.val10  = hdr.hdt[QNET_ADDR_W-1:0];
               msg_o.dt1  = cmd_i.msg.dt1;
               msg_o.dt0  = cmd_i.msg.dt0;
            end else begin
               msg_o.dt1 = param_i.rtd;
               msg_o.dt0 = T_LINK;
            end
         end
         SYNC1: begin
            if (cmd_i.net) begin
               pwr.we_off = 1'b1;
               pwr.val32  = cmd_i.msg.dt0 + cmd_i.msg.dt1;
               t_init     = 1'b1;
               // Accumulate one more hop of link delay
               msg_o.dt0  = cmd_i.msg.dt0 + T_LINK;
            end else begin
               msg_o.dt0 = T_LINK;
            end
         end
         UPDT_OFF: begin
            if (cmd_i.net) begin
               pwr.we_off = 1'b1;
               pwr.val32  = cmd_i.msg.dt0;
               t_updt     = 1'b1;
            end
            msg_o.dt1 = cmd_i.msg.dt1;
            msg_o.dt0 = cmd_i.msg.dt0;
         end
         SET_DT: begin
            if (cmd_i.net) begin
               pwr.we_dt = 1'b1;
               pwr.val64 = {cmd_i.msg.dt1, cmd_i.msg.dt0};
            end
            msg_o.dt1 = cmd_i.msg.dt1;
            msg_o.dt0 = cmd_i.msg.dt0;
         end
         GET_DT: begin
            // Answer back to the requesting node
            if (cmd_i.net) begin
               msg_o.hdr     = '0;
               msg_o.hdr.typ = QNET_TYPE_ANS;
               msg_o.hdr.id  = GET_DT;
               msg_o.hdr.dst = hdr.src;
               msg_o.hdr.src = param_i.id;
               msg_o.dt1     = param_i.dt[63:32];
               msg_o.dt0     = param_i.dt[31:0];
            end
         end
         default: begin
            msg_o.hdr = hdr;
         end
      endcase
   end

   // Effects only on the accepting cycle
   always_comb begin
      pwr_o        = pwr;
      pwr_o.we_id  = pwr.we_id && accept;
      pwr_o.we_nn  = pwr.we_nn && accept;
      pwr_o.we_rtd = pwr.we_rtd && accept;
      pwr_o.we_off = pwr.we_off && accept;
      pwr_o.we_dt  = pwr.we_dt && accept;
   end

   assign time_reset_o = t_reset && accept;
   assign time_init_o  = t_init && accept;
   assign time_updt_o  = t_updt && accept;

endmodule

// File: design/qnet_cmd_intake.sv
`timescale 1ns/1ps

module qnet_cmd_intake import qnet_pkg::*; (
   input  logic      t_clk_i,
   input  logic      t_rst_ni,
   // Local processor
   input  logic      loc_req_i,
   input  qnet_msg_t loc_cmd_i,
   output logic      loc_ack_o,
   // Network receiver
   input  logic      net_req_i,
   input  qnet_msg_t net_cmd_i,
   output logic      net_ack_o,
   // Command towards exec
   output logic      cmd_valid_o,
   output qnet_cmd_t cmd_o,
   input  logic      cmd_ready_i
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_OFFER,
      S_RELEASE
   } state_e;

   state_e    state_q;
   qnet_cmd_t cmd_q;
   logic      loc_ack_q;
   logic      net_ack_q;
   logic      free;
   logic      take_loc;
   logic      take_net;
   logic      src_req;

   // Idle with both acknowledges low, a new request may be taken
   assign free     = (state_q == S_IDLE) && !loc_ack_q && !net_ack_q;
   // Local source wins when both ask together
   assign take_loc = free && loc_req_i;
   assign take_net = free && !loc_req_i && net_req_i;

   // Request of the source that owns the current command
   assign src_req = loc_ack_q ? loc_req_i : net_req_i;

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         state_q   <= S_IDLE;
         loc_ack_q <= 1'b0;
         net_ack_q <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               // Ack went out last cycle, offer from now on
               if (loc_ack_q || net_ack_q) begin
                  state_q <= S_OFFER;
               end
               if (take_loc) begin
                  loc_ack_q <= 1'b1;
               end
               if (take_net) begin
                  net_ack_q <= 1'b1;
               end
            end
            S_OFFER: begin
               if (cmd_ready_i) begin
                  state_q <= S_RELEASE;
               end
            end
            S_RELEASE: begin
               // Four-phase end, wait for the request to drop
               if (!src_req) begin
                  loc_ack_q <= 1'b0;
                  net_ack_q <= 1'b0;
                  state_q   <= S_IDLE;
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Command capture
   always_ff @(posedge t_clk_i) begin
      if (take_loc) begin
         cmd_q <= '{msg: loc_cmd_i, net: 1'b0};
      end else if (take_net) begin
         cmd_q <= '{msg: net_cmd_i, net: 1'b1};
      end
   end

   assign cmd_valid_o = (state_q == S_OFFER);
   assign cmd_o       = cmd_q;
   assign loc_ack_o   = loc_ack_q;
   assign net_ack_o   = net_ack_q;

endmodule

// File: design/qnet_cmd_top.sv
`timescale 1ns/1ps

module qnet_cmd_top import qnet_pkg::*; #(
   parameter logic [31:0] T_LINK = 32'd20
) (
   input  logic        t_clk_i,
   input  logic        t_rst_ni,
   // Local command
   input  logic        loc_req_i,
   input  qnet_msg_t   loc_cmd_i,
   output logic        loc_ack_o,
   // Network command
   input  logic        net_req_i,
   input  qnet_msg_t   net_cmd_i,
   output logic        net_ack_o,
   // Transmit
   input  logic        slot_i,
   output logic        tx_req_o,
   output qnet_msg_t   tx_msg_o,
   input  logic        tx_ack_i,
   // Time control
   output logic        time_reset_o,
   output logic        time_init_o,
   output logic        time_updt_o,
   // Status
   output qnet_param_t param_o,
   output logic        cmd_err_o
);

   logic        cmd_valid;
   logic        cmd_ready;
   qnet_cmd_t   cmd;
   logic        msg_valid;
   logic        msg_ready;
   qnet_msg_t   msg;
   qnet_pwr_t   pwr;
   qnet_param_t param;

   ////////////////////////////////////////////////////////////
   // Command path
   ////////////////////////////////////////////////////////////

   qnet_cmd_intake u_intake (
      .t_clk_i     (t_clk_i),
      .t_rst_ni    (t_rst_ni),
      .loc_req_i   (loc_req_i),
      .loc_cmd_i   (loc_cmd_i),
      .loc_ack_o   (loc_ack_o),
      .net_req_i   (net_req_i),
      .net_cmd_i   (net_cmd_i),
      .net_ack_o   (net_ack_o),
      .cmd_valid_o (cmd_valid),
      .cmd_o       (cmd),
      .cmd_ready_i (cmd_ready)
   );

   qnet_cmd_exec #(
      .T_LINK (T_LINK)
   ) u_exec (
      .cmd_valid_i  (cmd_valid),
      .cmd_i        (cmd),
      .cmd_ready_o  (cmd_ready),
      .param_i      (param),
      .pwr_o        (pwr),
      .msg_valid_o  (msg_valid),
      .msg_o        (msg),
      .msg_ready_i  (msg_ready),
      .time_reset_o (time_reset_o),
      .time_init_o  (time_init_o),
      .time_updt_o  (time_updt_o),
      .cmd_err_o    (cmd_err_o)
   );

   qnet_node_regs u_regs (
      .t_clk_i  (t_clk_i),
      .t_rst_ni (t_rst_ni),
      .pwr_i    (pwr),
      .param_o  (param)
   );

   ////////////////////////////////////////////////////////////
   // Transmit
   ////////////////////////////////////////////////////////////

   qnet_tx_stage u_tx (
      .t_clk_i     (t_clk_i),
      .t_rst_ni    (t_rst_ni),
      .msg_valid_i (msg_valid),
      .msg_i       (msg),
      .msg_ready_o (msg_ready),
      .slot_i      (slot_i),
      .tx_req_o    (tx_req_o),
      .tx_msg_o    (tx_msg_o),
      .tx_ack_i    (tx_ack_i)
   );

   assign param_o = param;

endmodule

// File: design/qnet_node_regs.sv
`timescale 1ns/1ps

module qnet_node_regs import qnet_pkg::*; (
   input  logic        t_clk_i,
   input  logic        t_rst_ni,
   input  qnet_pwr_t   pwr_i,
   output qnet_param_t param_o
);

   qnet_param_t param_q;

   ////////////////////////////////////////////////////////////
   // Parameter bank
   ////////////////////////////////////////////////////////////

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         param_q <= '0;
      end else begin
         // Node position in the ring
         if (pwr_i.we_id) begin
            param_q.id <= pwr_i.val10;
         end
         // Nodes in the ring
         if (pwr_i.we_nn) begin
            param_q.nn <= pwr_i.val10;
         end
         // Round-trip delay
         if (pwr_i.we_rtd) begin
            param_q.rtd <= pwr_i.val32;
         end
         // Time offset
         if (pwr_i.we_off) begin
            param_q.off <= pwr_i.val32;
         end
         // Data pair for get_dt answers
         if (pwr_i.we_dt) begin
            param_q.dt <= pwr_i.val64;
         end
      end
   end

   assign param_o = param_q;

endmodule

// File: design/qnet_pkg.sv
package qnet_pkg;

   ////////////////////////////////////////////////////////////
   // Common widths
   ////////////////////////////////////////////////////////////

   // Node address, also used for node count and hop step
   localparam int unsigned QNET_ADDR_W = 10;

   ////////////////////////////////////////////////////////////
   // Command IDs
   ////////////////////////////////////////////////////////////

   typedef enum logic [4:0] {
      GET_NET  = 5'd1,
      SET_NET  = 5'd2,
      SYNC1    = 5'd3,
      UPDT_OFF = 5'd8,
      SET_DT   = 5'd10,
      GET_DT   = 5'd11
   } qnet_cmd_id_e;

   // Type code placed on a header that answers a request
   localparam logic [1:0] QNET_TYPE_ANS = 2'b10;

   ////////////////////////////////////////////////////////////
   // Header and message
   ////////////////////////////////////////////////////////////

   // 64-bit header, first field is the top bit
   typedef struct packed {
      logic [1:0]             typ;
      logic [4:0]             id;
      logic [2:0]             flg;
      logic [QNET_ADDR_W-1:0] dst;
      logic [QNET_ADDR_W-1:0] src;
      logic [QNET_ADDR_W-1:0] step;
      logic [23:0]            hdt;
   } qnet_hdr_t;

   // Header with its two data words, 128 bits
   typedef struct packed {
      qnet_hdr_t   hdr;
      logic [31:0] dt1;
      logic [31:0] dt0;
   } qnet_msg_t;

   // Captured command, tagged with its source
   typedef struct packed {
      qnet_msg_t msg;
      logic      net;
   } qnet_cmd_t;

   ////////////////////////////////////////////////////////////
   // Node parameters
   ////////////////////////////////////////////////////////////

   // One parameter write, applied on the next clock edge
   typedef struct packed {
      logic                   we_id;
      logic                   we_nn;
      logic                   we_rtd;
      logic                   we_off;
      logic                   we_dt;
      logic [QNET_ADDR_W-1:0] val10;
      logic [31:0]            val32;
      // Data pair as {dt1, dt0}
      logic [63:0]            val64;
   } qnet_pwr_t;

   // Network parameters kept by the node
   typedef struct packed {
      logic [QNET_ADDR_W-1:0] id;
      logic [QNET_ADDR_W-1:0] nn;
      logic [31:0]            rtd;
      logic [31:0]            off;
      // Stored pair as {dt1, dt0}
      logic [63:0]            dt;
   } qnet_param_t;

endpackage

// File: design/qnet_tx_stage.sv
`timescale 1ns/1ps

module qnet_tx_stage import qnet_pkg::*; (
   input  logic      t_clk_i,
   input  logic      t_rst_ni,
   // Message from exec
   input  logic      msg_valid_i,
   input  qnet_msg_t msg_i,
   output logic      msg_ready_o,
   // Transmit slot and link
   input  logic      slot_i,
   output logic      tx_req_o,
   output qnet_msg_t tx_msg_o,
   input  logic      tx_ack_i
);

   logic      full_q;
   logic      req_q;
   qnet_msg_t msg_q;
   logic      load;
   logic      done;

   assign msg_ready_o = !full_q;
   assign load        = msg_valid_i && !full_q;
   assign done        = req_q && tx_ack_i;

   always_ff @(posedge t_clk_i or negedge t_rst_ni) begin
      if (!t_rst_ni) begin
         full_q <= 1'b0;
         req_q  <= 1'b0;
      end else begin
         if (load) begin
            full_q <= 1'b1;
         end else if (done) begin
            full_q <= 1'b0;
         end
         // Request only inside a transmit slot
         if (full_q && !req_q && slot_i) begin
            req_q <= 1'b1;
         end else if (done) begin
            req_q <= 1'b0;
         end
      end
   end

   // Held message
   always_ff @(posedge t_clk_i) begin
      if (load) begin
         msg_q <= msg_i;
      end
   end

   assign tx_req_o = req_q;
   assign tx_msg_o = msg_q;

endmodule

// File: dv/qnet_tb_checker.sv
`timescale 1ns/1ps

module qnet_tb_checker import qnet_pkg::*; #(
   parameter logic [31:0] T_LINK = 32'd20
) (
   input  logic        t_clk_i,
   input  logic        t_rst_ni,
   // DUT ports under watch
   input  logic        loc_req_i,
   input  qnet_msg_t   loc_cmd_i,
   input  logic        loc_ack_i,
   input  logic        net_req_i,
   input  qnet_msg_t   net_cmd_i,
   input  logic        net_ack_i,
   input  logic        slot_i,
   input  logic        tx_req_i,
   input  qnet_msg_t   tx_msg_i,
   input  logic        tx_ack_i,
   input  logic        time_reset_i,
   input  logic        time_init_i,
   input  logic        time_updt_i,
   input  qnet_param_t param_i,
   input  logic        cmd_err_i,
   // Test sequencing
   input  logic [2:0]  test_i,
   input  logic        test_end_i,
   input  logic        summary_i,
   output int          errors_o,
   output int          pending_o
);

   qnet_param_t model;
   qnet_param_t param_exp;
   qnet_msg_t   msg_exp;
   qnet_msg_t   msg_q[$];
   logic [3:0]  strobe_q[$];
   qnet_param_t snap_q[$];
   logic [3:0]  strobes;
   logic [3:0]  strobe_exp;
   logic        param_due;
   logic        loc_ack_d;
   logic        net_ack_d;
   logic        loc_req_d;
   logic        net_req_d;
   logic        tx_req_d;
   logic        tx_ack_d;
   logic        slot_d;
   int          errors = 0;
   int          checks = 0;
   int          cmds = 0;
   int          tests = 0;
   int          test_errors = 0;
   int          test_cmds = 0;

   task automatic report_error(input string what);
      $display("ERROR at %0t: %s", $time, what);
      errors++;
      test_errors++;
   endtask

   task automatic report_mismatch(input string sig, input logic [147:0] exp_v,
                                  input logic [147:0] got_v);
      $display("MISMATCH %s: expected %0h, got %0h at %0t", sig, exp_v, got_v, $time);
      errors++;
      test_errors++;
   endtask

   function automatic string test_name(input logic [2:0] t);
      case (t)
         3'd1:    return "get_net";
         3'd2:    return "set_net";
         3'd3:    return "sync1 and updt_off";
         3'd4:    return "set_dt and get_dt";
         3'd5:    return "source priority";
         default: return "unknown id and back-pressure";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Reference model of one accepted command
   ////////////////////////////////////////////////////////////

   // Strobe code is {cmd_err, time_updt, time_init, time_reset}
   task automatic predict(input qnet_msg_t c, input logic net);
      qnet_msg_t   m;
      logic [63:0] h;
      logic [3:0]  stb;
      logic        send;
      m     = '0;
      m.hdr = c.hdr;
      stb   = 4'b0000;
      send  = 1'b1;
      case (c.hdr.id)
         GET_NET: begin
            if (net) begin
               model.id = c.hdr.hdt[QNET_ADDR_W-1:0];
               h        = c.hdr;
               h        = h + 64'd1;
               m.hdr    = h;
               stb      = 4'b0001;
            end else begin
               model.id = 10'd1;
            end
         end
         SET_NET: begin
            if (net) begin
               model.rtd = c.dt1;
               model.nn  = c.hdr.hdt[QNET_ADDR_W-1:0];
               m         = c;
            end else begin
               m.dt0 = T_LINK;
               m.dt1 = model.rtd;
            end
         end
         SYNC1: begin
            model.off = c.dt0 + c.dt1;
            m.dt0     = c.dt0 + T_LINK;
            stb       = 4'b0010;
         end
         UPDT_OFF: begin
            model.off = c.dt0;
            m         = c;
            stb       = 4'b0100;
         end
         SET_DT: begin
            if (net) begin
               model.dt = {c.dt1, c.dt0};
            end
            m = c;
         end
         GET_DT: begin
            if (net) begin
               m.hdr.typ  = QNET_TYPE_ANS;
               m.hdr.id   = GET_DT;
               m.hdr.flg  = '0;
               m.hdr.dst  = c.hdr.src;
               m.hdr.src  = model.id;
               m.hdr.step = '0;
               m.hdr.hdt  = '0;
               m.dt1      = model.dt[63:32];
               m.dt0      = model.dt[31:0];
            end
         end
         default: begin
            send = 1'b0;
            stb  = 4'b1000;
         end
      endcase
      if (send) begin
         msg_q.push_back(m);
      end
      if (stb != 4'b0000) begin
         strobe_q.push_back(stb);
         snap_q.push_back(model);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Port monitor
   ////////////////////////////////////////////////////////////

   always @(posedge t_clk_i) begin
      if (!t_rst_ni) begin
         model = '0;
         msg_q.delete();
         strobe_q.delete();
         snap_q.delete();
         param_due = 1'b0;
         loc_ack_d = 1'b0;
         net_ack_d = 1'b0;
         loc_req_d = 1'b0;
         net_req_d = 1'b0;
         tx_req_d  = 1'b0;
         tx_ack_d  = 1'b0;
         slot_d    = 1'b0;
      end else begin
         // Four-phase and priority rules
         if (loc_ack_i && net_ack_i) begin
            report_error("both acknowledges high together");
         end
         if (net_ack_i && !net_ack_d && loc_req_d) begin
            report_error("network acknowledged while a local request was waiting");
         end
         if (!loc_ack_i && loc_ack_d && loc_req_d) begin
            report_error("loc_ack_o fell while loc_req_i was still high");
         end
         if (!net_ack_i && net_ack_d && net_req_d) begin
            report_error("net_ack_o fell while net_req_i was still high");
         end
         // Commands enter the model in acknowledge order
         if (loc_ack_i && !loc_ack_d) begin
            test_cmds++;
            predict(loc_cmd_i, 1'b0);
         end
         if (net_ack_i && !net_ack_d) begin
            test_cmds++;
            predict(net_cmd_i, 1'b1);
         end
         // Written values show one cycle after the strobe
         if (param_due) begin
            checks++;
            param_due = 1'b0;
            if (param_i !== param_exp) begin
               report_mismatch("param_o", param_exp, param_i);
            end
         end
         strobes = {cmd_err_i, time_updt_i, time_init_i, time_reset_i};
         if (strobes != 4'b0000) begin
            if (strobe_q.size() == 0) begin
               report_error("strobe pulse with no command waiting for one");
            end else begin
               checks++;
               strobe_exp = strobe_q.pop_front();
               param_exp  = snap_q.pop_front();
               param_due  = 1'b1;
               if (strobes !== strobe_exp) begin
                  report_mismatch("strobes", strobe_exp, strobes);
               end
            end
         end
         // Outgoing messages leave in command order
         if (tx_req_i && !tx_req_d) begin
            if (!slot_d) begin
               report_error("tx_req_o rose without a transmit slot");
            end
            if (msg_q.size() == 0) begin
               report_error("message sent while none was expected");
            end else begin
               checks++;
               msg_exp = msg_q.pop_front();
               if (tx_msg_i !== msg_exp) begin
                  report_mismatch("tx_msg_o", msg_exp, tx_msg_i);
               end
            end
         end
         if (tx_req_i && tx_req_d && tx_ack_d) begin
            report_error("tx_req_o still high one cycle after tx_ack_i");
         end
         if (test_end_i) begin
            checks++;
            if (param_i !== model) begin
               report_mismatch("param_o", model, param_i);
            end
            if (msg_q.size() != 0 || strobe_q.size() != 0) begin
               report_error("test ended with results still outstanding");
            end
            tests++;
            cmds += test_cmds;
            $display("test %0d %s: %0d commands, %0d errors",
                     test_i, test_name(test_i), test_cmds, test_errors);
            test_cmds   = 0;
            test_errors = 0;
         end
         if (summary_i) begin
            $display("Summary: %0d tests, %0d commands, %0d checks, %0d errors",
                     tests, cmds, checks, errors);
         end
         loc_ack_d = loc_ack_i;
         net_ack_d = net_ack_i;
         loc_req_d = loc_req_i;
         net_req_d = net_req_i;
         tx_req_d  = tx_req_i;
         tx_ack_d  = tx_ack_i;
         slot_d    = slot_i;
      end
      errors_o  = errors;
      pending_o = msg_q.size() + strobe_q.size();
   end

endmodule

// File: dv/qnet_tb_top.sv
`timescale 1ns/1ps

module qnet_tb_top import qnet_pkg::*; ();

   localparam logic [31:0] T_LINK = 32'd37;
   // Longest wait for outstanding results once both sources are done
   localparam int DRAIN_LIMIT = 200;

   logic        t_clk;
   logic        t_rst_n;
   logic        loc_req;
   qnet_msg_t   loc_cmd;
   logic        loc_ack;
   logic        net_req;
   qnet_msg_t   net_cmd;
   logic        net_ack;
   logic        slot;
   logic        tx_req;
   qnet_msg_t   tx_msg;
   logic        tx_ack;
   logic        time_reset;
   logic        time_init;
   logic        time_updt;
   qnet_param_t param;
   logic        cmd_err;
   logic        slow_link;
   logic [2:0]  test_num;
   logic        test_end;
   logic        summary;
   int          errors;
   int          pending;

   qnet_cmd_top #(
      .T_LINK (T_LINK)
   ) dut (
      .t_clk_i      (t_clk),
      .t_rst_ni     (t_rst_n),
      .loc_req_i    (loc_req),
      .loc_cmd_i    (loc_cmd),
      .loc_ack_o    (loc_ack),
      .net_req_i    (net_req),
      .net_cmd_i    (net_cmd),
      .net_ack_o    (net_ack),
      .slot_i       (slot),
      .tx_req_o     (tx_req),
      .tx_msg_o     (tx_msg),
      .tx_ack_i     (tx_ack),
      .time_reset_o (time_reset),
      .time_init_o  (time_init),
      .time_updt_o  (time_updt),
      .param_o      (param),
      .cmd_err_o    (cmd_err)
   );

   qnet_tb_checker #(
      .T_LINK (T_LINK)
   ) u_checker (
      .t_clk_i      (t_clk),
      .t_rst_ni     (t_rst_n),
      .loc_req_i    (loc_req),
      .loc_cmd_i    (loc_cmd),
      .loc_ack_i    (loc_ack),
      .net_req_i    (net_req),
      .net_cmd_i    (net_cmd),
      .net_ack_i    (net_ack),
      .slot_i       (slot),
      .tx_req_i     (tx_req),
      .tx_msg_i     (tx_msg),
      .tx_ack_i     (tx_ack),
      .time_reset_i (time_reset),
      .time_init_i  (time_init),
      .time_updt_i  (time_updt),
      .param_i      (param),
      .cmd_err_i    (cmd_err),
      .test_i       (test_num),
      .test_end_i   (test_end),
      .summary_i    (summary),
      .errors_o     (errors),
      .pending_o    (pending)
   );

   initial t_clk = 1'b0;
   always #5 t_clk = ~t_clk;

   // Commands per source in each test
   function automatic int loc_count(input int t);
      case (t)
         1:       return 6;
         2:       return 8;
         3:       return 0;
         4:       return 8;
         5:       return 12;
         default: return 10;
      endcase
   endfunction

   function automatic int net_count(input int t);
      case (t)
         3:       return 16;
         4:       return 14;
         5:       return 12;
         6:       return 14;
         default: return 10;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   function automatic logic [4:0] pick_id(input int t, input logic net);
      logic [4:0] id;
      case (t)
         1: id = GET_NET;
         2: id = SET_NET;
         3: id = $urandom_range(1, 0) ? SYNC1 : UPDT_OFF;
         4: id = $urandom_range(1, 0) ? SET_DT : GET_DT;
         default: begin
            // Local side never issues sync1 or updt_off
            case ($urandom_range(net ? 5 : 3, 0))
               0:       id = GET_NET;
               1:       id = SET_NET;
               2:       id = SET_DT;
               3:       id = GET_DT;
               4:       id = SYNC1;
               default: id = UPDT_OFF;
            endcase
            if (t == 6 && $urandom_range(3, 0) == 0) begin
               id = 5'($urandom);
               while (id inside {GET_NET, SET_NET, SYNC1, UPDT_OFF, SET_DT, GET_DT}) begin
                  id = 5'($urandom);
               end
            end
         end
      endcase
      return id;
   endfunction

   function automatic qnet_msg_t make_cmd(input int t, input logic net);
      qnet_msg_t m;
      m        = {$urandom, $urandom, $urandom, $urandom};
      m.hdr.id = pick_id(t, net);
      return m;
   endfunction

   task automatic step_cycle();
      @(posedge t_clk);
      #1;
   endtask

   // Four-phase source that holds its command until the next request
   task automatic run_source(input int t, input logic net, input int n, input int max_gap);
      qnet_msg_t c;
      for (int i = 0; i < n; i++) begin
         repeat ($urandom_range(max_gap, 0)) step_cycle();
         c = make_cmd(t, net);
         if (net) begin
            net_cmd = c;
            net_req = 1'b1;
         end else begin
            loc_cmd = c;
            loc_req = 1'b1;
         end
         do step_cycle(); while (!(net ? net_ack : loc_ack));
         repeat ($urandom_range(3, 0)) step_cycle();
         if (net) begin
            net_req = 1'b0;
         end else begin
            loc_req = 1'b0;
         end
         while (net ? net_ack : loc_ack) step_cycle();
      end
   endtask

   task automatic run_test(input int t);
      int wait_cycles;
      test_num  = 3'(t);
      slow_link = (t == 6);
      fork
         run_source(t, 1'b0, loc_count(t), (t == 5) ? 0 : 3);
         run_source(t, 1'b1, net_count(t), (t == 5) ? 0 : 3);
      join
      // Drain until every expected result is seen or the wait runs out
      wait_cycles = 0;
      while ((pending != 0 || loc_ack || net_ack) && wait_cycles < DRAIN_LIMIT) begin
         step_cycle();
         wait_cycles++;
      end
      test_end = 1'b1;
      step_cycle();
      test_end = 1'b0;
   endtask

   initial begin : main
      void'($urandom(45));
      t_rst_n   = 1'b0;
      loc_req   = 1'b0;
      loc_cmd   = '0;
      net_req   = 1'b0;
      net_cmd   = '0;
      slow_link = 1'b0;
      test_num  = 3'd0;
      test_end  = 1'b0;
      summary   = 1'b0;
      repeat (3) @(posedge t_clk);
      #1;
      t_rst_n = 1'b1;
      for (int t = 1; t <= 6; t++) begin
         run_test(t);
      end
      summary = 1'b1;
      step_cycle();
      summary = 1'b0;
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Link and slot models
   ////////////////////////////////////////////////////////////

   initial begin : slot_model
      slot = 1'b0;
      forever begin
         step_cycle();
         slot = ($urandom_range(2, 0) == 0);
      end
   end

   // Last test keeps the acknowledge back long enough to stall exec
   initial begin : link_model
      int delay;
      tx_ack = 1'b0;
      forever begin
         step_cycle();
         if (tx_req && !tx_ack) begin
            delay = slow_link ? $urandom_range(20, 8) : $urandom_range(4, 1);
            repeat (delay - 1) step_cycle();
            tx_ack = 1'b1;
            while (tx_req) step_cycle();
            tx_ack = 1'b0;
         end
      end
   end

   initial begin : watchdog
      int limit;
      limit = 0;
      for (int t = 1; t <= 6; t++) begin
         limit += 200 * (loc_count(t) + net_count(t));
      end
      repeat (limit) @(posedge t_clk);
      $display("TIMEOUT: run still busy after %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule
